//--- hdl/eth_host_pkg.sv
`default_nettype none

// host side of the DM9000 access controller.
package eth_host_pkg;

    // chip register index carried by one host access.
    localparam int REG_ADDR_W = 8;

    // host data and chip data bus width.
    localparam int DATA_W = 16;

    // sequencer phases of one host access.
    typedef enum logic {
        SEQ_IDLE = 1'b0, // waiting for a host strobe.
        SEQ_DATA = 1'b1  // index entry pushed, data entry next.
    } seq_state_t;

endpackage

`default_nettype wire

//--- hdl/eth_chip_pkg.sv
`default_nettype none

// chip side command encoding.
package eth_chip_pkg;

    localparam int OP_W = 2;

    typedef enum logic [OP_W-1:0] {
        OP_INDEX = 2'd0, // index write, cmd low.
        OP_WRITE = 2'd1, // data write, cmd high.
        OP_READ  = 2'd2  // data read, cmd high.
    } chip_op_t;

    // opcode on top, data word below.
    localparam int CMD_W = OP_W + eth_host_pkg::DATA_W;

    typedef enum logic [1:0] {
        PORT_IDLE   = 2'd0,
        PORT_STROBE = 2'd1,
        PORT_HOLD   = 2'd2
    } port_state_t;

endpackage

`default_nettype wire

//--- hdl/eth_cmd_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module eth_cmd_sequencer #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                host_write,
    input  wire logic                                host_read,
    input  wire logic [eth_host_pkg::REG_ADDR_W-1:0] host_reg,
    input  wire logic [eth_host_pkg::DATA_W-1:0]     host_wdata,
    input  wire logic [$clog2(FIFO_DEPTH):0]         free_slots,
    output logic                                     host_busy,
    output logic                                     push,
    output logic [eth_chip_pkg::CMD_W-1:0]           push_cmd
);

    localparam int FREE_W = $clog2(FIFO_DEPTH) + 1;

    eth_host_pkg::seq_state_t state;
    logic                            accept;
    logic                            rd_q;
    logic [eth_host_pkg::DATA_W-1:0] wdata_q;

    // a push still in flight is not yet counted by the FIFO.
    assign host_busy = (state == eth_host_pkg::SEQ_DATA) ||
                       (free_slots < (FREE_W'(2) + FREE_W'(push)));

    assign accept = (host_write || host_read) && !host_busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= eth_host_pkg::SEQ_IDLE;
            push  <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                eth_host_pkg::SEQ_IDLE: begin
                    if (accept) begin
                        push  <= 1'b1; // index entry.
                        state <= eth_host_pkg::SEQ_DATA;
                    end
                end
                eth_host_pkg::SEQ_DATA: begin
                    push  <= 1'b1; // data entry, always adjacent.
                    state <= eth_host_pkg::SEQ_IDLE;
                end
                default: state <= eth_host_pkg::SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == eth_host_pkg::SEQ_IDLE) begin
            if (accept) begin
                rd_q     <= host_read && !host_write; // write wins a double strobe.
                wdata_q  <= host_wdata;
                push_cmd <= {eth_chip_pkg::OP_INDEX,
                             eth_host_pkg::DATA_W'(host_reg)};
            end
        end else begin
            if (rd_q) begin
                push_cmd <= {eth_chip_pkg::OP_READ, eth_host_pkg::DATA_W'(0)};
            end else begin
                push_cmd <= {eth_chip_pkg::OP_WRITE, wdata_q};
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/eth_cmd_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module eth_cmd_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           push,
    input  wire logic [eth_chip_pkg::CMD_W-1:0] push_cmd,
    input  wire logic                           pop,
    output logic [eth_chip_pkg::CMD_W-1:0]      pop_cmd,
    output logic                                empty,
    output logic [$clog2(FIFO_DEPTH):0]         free_slots
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [eth_chip_pkg::CMD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]               wr_ptr;
    logic [PTR_W-1:0]               rd_ptr;
    logic [CNT_W-1:0]               count;
    logic                           do_push;
    logic                           do_pop;

    assign empty      = (count == '0);
    assign free_slots = CNT_W'(FIFO_DEPTH) - count;
    assign pop_cmd    = mem[rd_ptr]; // head entry.

    assign do_push = push && (count != CNT_W'(FIFO_DEPTH));
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

    // pointers wrap on their own, depth is a power of two.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither.
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/eth_chip_port.sv
`timescale 1ns/10ps
`default_nettype none

module eth_chip_port (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            empty,
    input  wire logic [eth_chip_pkg::CMD_W-1:0]  pop_cmd,
    input  wire logic [eth_host_pkg::DATA_W-1:0] sd_in,
    input  wire logic                            chip_intr,
    output logic                                 pop,
    output logic                                 cs_n,
    output logic                                 ior_n,
    output logic                                 iow_n,
    output logic                                 cmd,
    output logic [eth_host_pkg::DATA_W-1:0]      sd_out,
    output logic                                 sd_oe,
    output logic [eth_host_pkg::DATA_W-1:0]      host_rdata,
    output logic                                 host_rdata_valid,
    output logic                                 irq
);

    eth_chip_pkg::port_state_t       state;
    eth_chip_pkg::chip_op_t          head_op;
    logic [eth_host_pkg::DATA_W-1:0] head_data;
    logic [eth_host_pkg::DATA_W-1:0] wdata_q;
    logic                            intr_meta;

    assign head_op   = eth_chip_pkg::chip_op_t'(pop_cmd[eth_chip_pkg::CMD_W-1 -:
                                                        eth_chip_pkg::OP_W]);
    assign head_data = pop_cmd[eth_host_pkg::DATA_W-1:0];

    // head is taken in the same cycle it is decoded.
    assign pop = (state == eth_chip_pkg::PORT_IDLE) && !empty;

    assign sd_out = sd_oe ? wdata_q : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state            <= eth_chip_pkg::PORT_IDLE;
            cs_n             <= 1'b1;
            ior_n            <= 1'b1;
            iow_n            <= 1'b1;
            cmd              <= 1'b0;
            sd_oe            <= 1'b0;
            host_rdata_valid <= 1'b0;
        end else begin
            host_rdata_valid <= 1'b0;
            case (state)
                eth_chip_pkg::PORT_IDLE: begin
                    if (pop) begin
                        cs_n  <= 1'b0;
                        cmd   <= (head_op != eth_chip_pkg::OP_INDEX); // low selects index.
                        iow_n <= (head_op == eth_chip_pkg::OP_READ);
                        ior_n <= (head_op != eth_chip_pkg::OP_READ);
                        sd_oe <= (head_op != eth_chip_pkg::OP_READ);
                        state <= eth_chip_pkg::PORT_STROBE;
                    end
                end
                eth_chip_pkg::PORT_STROBE: begin
                    // chip drives sd_in only while ior_n is low.
                    host_rdata_valid <= !ior_n;
                    ior_n            <= 1'b1;
                    iow_n            <= 1'b1;
                    state            <= eth_chip_pkg::PORT_HOLD;
                end
                eth_chip_pkg::PORT_HOLD: begin
                    cs_n  <= 1'b1; // data held through this phase.
                    sd_oe <= 1'b0;
                    state <= eth_chip_pkg::PORT_IDLE;
                end
                default: state <= eth_chip_pkg::PORT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            wdata_q <= head_data;
        end
        if (state == eth_chip_pkg::PORT_STROBE && !ior_n) begin
            host_rdata <= sd_in;
        end
    end

    // two flop synchronizer.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            intr_meta <= 1'b0;
            irq       <= 1'b0;
        end else begin
            intr_meta <= chip_intr;
            irq       <= intr_meta;
        end
    end

endmodule

`default_nettype wire

//--- hdl/eth_controller_top.sv
`timescale 1ns/10ps
`default_nettype none

module eth_controller_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                host_write,
    input  wire logic                                host_read,
    input  wire logic [eth_host_pkg::REG_ADDR_W-1:0] host_reg,
    input  wire logic [eth_host_pkg::DATA_W-1:0]     host_wdata,
    output logic                                     host_busy,
    output logic [eth_host_pkg::DATA_W-1:0]          host_rdata,
    output logic                                     host_rdata_valid,
    output logic                                     cs_n,
    output logic                                     ior_n,
    output logic                                     iow_n,
    output logic                                     cmd,
    output logic [eth_host_pkg::DATA_W-1:0]          sd_out,
    output logic                                     sd_oe,
    input  wire logic [eth_host_pkg::DATA_W-1:0]     sd_in,
    input  wire logic                                chip_intr,
    output logic                                     irq
);

    logic                           push;
    logic [eth_chip_pkg::CMD_W-1:0] push_cmd;
    logic [$clog2(FIFO_DEPTH):0]    free_slots;
    logic                           pop;
    logic [eth_chip_pkg::CMD_W-1:0] pop_cmd;
    logic                           empty;

    eth_cmd_sequencer #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) eth_cmd_sequencer_inst (
        .clk       (clk),
        .rst       (rst),
        .host_write(host_write),
        .host_read (host_read),
        .host_reg  (host_reg),
        .host_wdata(host_wdata),
        .free_slots(free_slots),
        .host_busy (host_busy),
        .push      (push),
        .push_cmd  (push_cmd)
    );

    eth_cmd_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) eth_cmd_fifo_inst (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_cmd  (push_cmd),
        .pop       (pop),
        .pop_cmd   (pop_cmd),
        .empty     (empty),
        .free_slots(free_slots)
    );

    eth_chip_port eth_chip_port_inst (
        .clk             (clk),
        .rst             (rst),
        .empty           (empty),
        .pop_cmd         (pop_cmd),
        .sd_in           (sd_in),
        .chip_intr       (chip_intr),
        .pop             (pop),
        .cs_n            (cs_n),
        .ior_n           (ior_n),
        .iow_n           (iow_n),
        .cmd             (cmd),
        .sd_out          (sd_out),
        .sd_oe           (sd_oe),
        .host_rdata      (host_rdata),
        .host_rdata_valid(host_rdata_valid),
        .irq             (irq)
    );

endmodule

`default_nettype wire

//--- verification/eth_controller_props.sv
`timescale 1ns/10ps
`default_nettype none

module eth_controller_props (
    input wire logic clk,
    input wire logic rst,
    input wire logic host_write,
    input wire logic host_read,
    input wire logic host_busy,
    input wire logic host_rdata_valid,
    input wire logic cs_n,
    input wire logic ior_n,
    input wire logic iow_n,
    input wire logic sd_oe
);

    strobe_exclusive: assert property (@(posedge clk) disable iff (rst) ior_n || iow_n)
        else $error("ior_n and iow_n low together");

    strobe_in_select: assert property (@(posedge clk) disable iff (rst)
        (!ior_n || !iow_n) |-> !cs_n)
        else $error("strobe low while cs_n is high");

    // the chip owns the bus during a read.
    no_drive_on_read: assert property (@(posedge clk) disable iff (rst) !(sd_oe && !ior_n))
        else $error("sd_oe high while ior_n is low");

    valid_after_read: assert property (@(posedge clk) disable iff (rst)
        host_rdata_valid |-> $past(!ior_n))
        else $error("host_rdata_valid without a read strobe before it");

    busy_after_accept: assert property (@(posedge clk) disable iff (rst)
        ((host_write || host_read) && !host_busy) |=> host_busy)
        else $error("host_busy low in the data phase of an access");

endmodule

bind eth_controller_top eth_controller_props eth_controller_props_inst (
    .clk             (clk),
    .rst             (rst),
    .host_write      (host_write),
    .host_read       (host_read),
    .host_busy       (host_busy),
    .host_rdata_valid(host_rdata_valid),
    .cs_n            (cs_n),
    .ior_n           (ior_n),
    .iow_n           (iow_n),
    .sd_oe           (sd_oe)
);

`default_nettype wire

//--- verification/eth_controller_tb.sv
`timescale 1ns/10ps
`default_nettype none

module eth_controller_tb;

    logic                                clk;
    logic                                rst;
    logic                                host_write;
    logic                                host_read;
    logic [eth_host_pkg::REG_ADDR_W-1:0] host_reg;
    logic [eth_host_pkg::DATA_W-1:0]     host_wdata;
    logic                                host_busy;
    logic [eth_host_pkg::DATA_W-1:0]     host_rdata;
    logic                                host_rdata_valid;
    logic                                cs_n;
    logic                                ior_n;
    logic                                iow_n;
    logic                                cmd;
    logic [eth_host_pkg::DATA_W-1:0]     sd_out;
    logic                                sd_oe;
    logic [eth_host_pkg::DATA_W-1:0]     sd_in;
    logic                                chip_intr;
    logic                                irq;

    logic [eth_host_pkg::DATA_W-1:0]     chip_regs [2**eth_host_pkg::REG_ADDR_W];
    logic [eth_host_pkg::REG_ADDR_W-1:0] chip_index;
    byte                                 row_op [$];
    logic [15:0]                         row_a [$];
    logic [15:0]                         row_b [$];
    logic [eth_host_pkg::DATA_W-1:0]     exp_q [$];
    bit                                  rows_loaded;
    bit                                  stall_seen;
    int                                  idx;

    eth_controller_top #(
        .FIFO_DEPTH(4)
    ) eth_controller_top_inst (
        .clk             (clk),
        .rst             (rst),
        .host_write      (host_write),
        .host_read       (host_read),
        .host_reg        (host_reg),
        .host_wdata      (host_wdata),
        .host_busy       (host_busy),
        .host_rdata      (host_rdata),
        .host_rdata_valid(host_rdata_valid),
        .cs_n            (cs_n),
        .ior_n           (ior_n),
        .iow_n           (iow_n),
        .cmd             (cmd),
        .sd_out          (sd_out),
        .sd_oe           (sd_oe),
        .sd_in           (sd_in),
        .chip_intr       (chip_intr),
        .irq             (irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s at %0t", reason, $time);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s got 0x%0h expected 0x%0h",
                     $time, name, actual, expected);
            stop_with_failure("value mismatch");
        end
    endtask

    // chip register model, updated on the edge that ends a write strobe.
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**eth_host_pkg::REG_ADDR_W; i++) begin
                chip_regs[i] <= '0;
            end
            chip_index <= '0;
        end else if (!iow_n) begin
            check_value("sd_oe", sd_oe, 1);
            if (!cmd) begin
                chip_index <= sd_out[eth_host_pkg::REG_ADDR_W-1:0];
            end else begin
                chip_regs[chip_index] <= sd_out;
            end
        end
    end

    assign sd_in = (!ior_n && cmd) ? chip_regs[chip_index] : '0;

    always @(negedge clk) begin
        if (!rst && host_rdata_valid) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("read-valid pulse with no read outstanding");
            end else begin
                check_value("host_rdata", host_rdata, exp_q.pop_front());
            end
        end
    end

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        byte         op;
        logic [15:0] a;
        logic [15:0] b;
        fd = $fopen("verification/eth_patterns.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open verification/eth_patterns.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            a = '0;
            b = '0;
            n = $sscanf(line, "%c %h %h", op, a, b);
            if (n >= 2 && op != "#") begin // skips comment and blank lines.
                row_op.push_back(op);
                row_a.push_back(a);
                row_b.push_back(b);
            end
        end
        $fclose(fd);
        rows_loaded = 1'b1;
    endtask

    task automatic do_access(input bit is_write, input logic [15:0] reg_idx,
                             input logic [15:0] data);
        int waits;
        waits = 0;
        @(negedge clk);
        while (host_busy) begin
            waits++;
            @(negedge clk);
        end
        if (waits > 1) begin
            stall_seen = 1'b1; // busy past the data phase means a full FIFO.
        end
        @(posedge clk);
        host_write <= is_write;
        host_read  <= !is_write;
        host_reg   <= reg_idx[eth_host_pkg::REG_ADDR_W-1:0];
        host_wdata <= data;
        @(negedge clk);
        check_value("host_busy", host_busy, 0);
        @(posedge clk);
        host_write <= 1'b0;
        host_read  <= 1'b0;
    endtask

    task automatic run_access(input int row);
        if (row_op[row] == "R") begin
            exp_q.push_back(row_b[row]);
        end
        do_access(row_op[row] == "W", row_a[row], row_b[row]);
    endtask

    task automatic wait_reads_done();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic run_burst(input int first, input int count);
        if (first + count > row_op.size()) begin
            stop_with_failure("burst runs past the end of the pattern file");
        end
        stall_seen = 1'b0;
        for (int j = 0; j < count; j++) begin
            run_access(first + j);
        end
        wait_reads_done();
        check_value("host_busy stall in burst", stall_seen, 1);
    endtask

    task automatic set_interrupt(input logic level);
        int n;
        n = 0;
        @(posedge clk);
        chip_intr <= level;
        do begin
            @(negedge clk);
            n++;
        end while (irq !== level && n < 4);
        check_value("irq", irq, level);
    endtask

    initial begin
        wait (rows_loaded);
        repeat (row_op.size() * 40 + 100) @(posedge clk);
        stop_with_failure("watchdog expired before the patterns finished");
    end

    initial begin
        rst          = 1'b1;
        host_write   = 1'b0;
        host_read    = 1'b0;
        host_reg     = '0;
        host_wdata   = '0;
        chip_intr    = 1'b0;
        load_patterns();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("cs_n", cs_n, 1);
        check_value("ior_n", ior_n, 1);
        check_value("iow_n", iow_n, 1);
        check_value("irq", irq, 0);
        check_value("host_busy", host_busy, 0);
        check_value("host_rdata_valid", host_rdata_valid, 0);
        idx = 0;
        while (idx < row_op.size()) begin
            case (row_op[idx])
                "W", "R": begin
                    run_access(idx);
                    wait_reads_done();
                end
                "I": set_interrupt(row_a[idx][0]);
                "G": begin
                    run_burst(idx + 1, int'(row_a[idx]));
                    idx += int'(row_a[idx]); // burst rows already consumed.
                end
                default: stop_with_failure("unknown operation in pattern file");
            endcase
            idx++;
        end
        wait_reads_done();
        // a second valid pulse for the last read shows within one command time.
        repeat (4) @(negedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/eth_patterns.txt
# columns: op reg data, all hex. W writes data to reg, R reads reg and expects data
# I level sets chip_intr; G n issues the next n rows back to back
W 05 a5c3
R 05 a5c3
W 10 1234
W 21 beef
W 3f 0f0f
R 3f 0f0f
R 10 1234
R 21 beef
R 05 a5c3
I 1 0
I 0 0
G 8
W 40 0001
W 41 0002
W 42 0003
R 40 0001
W 43 0004
R 42 0003
R 43 0004
R 41 0002
R 7e 0000
W 05 5a5a
R 05 5a5a

//--- vlog.f
hdl/eth_host_pkg.sv
hdl/eth_chip_pkg.sv
hdl/eth_cmd_sequencer.sv
hdl/eth_cmd_fifo.sv
hdl/eth_chip_port.sv
hdl/eth_controller_top.sv
verification/eth_controller_props.sv
verification/eth_controller_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module eth_controller_tb -f vlog.f \
    --Mdir obj_dir -o eth_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/eth_sim > sim.log 2>&1

grep -q "^SIMULATION PASSED$" sim.log && echo "result: pass" \
    || { echo "result: fail, see sim.log"; exit 1; }
